// File: hw/l2_interconnect.sv
/*
 * L2 interconnect
 * Decodes master addresses to interleaved or private banks, arbitrates
 * each bank round-robin and routes responses back. Unmapped accesses
 * are granted at once and answered with an error one cycle later
 */

`timescale 1ns/10ps

`include "soc_mem_map.svh"

module l2_interconnect #(
   parameter int unsigned NB_MASTERS      = 2,
   parameter int unsigned NB_BANKS        = 4,
   parameter int unsigned INTL_BANK_WORDS = 256,
   parameter int unsigned PRI_BANK_WORDS  = 256
) (
   input  logic            clk_i,
   input  logic            rst_ni,
   input  l2_pkg::l2_req_t master_req_i [NB_MASTERS],
   output l2_pkg::l2_rsp_t master_rsp_o [NB_MASTERS],
   output l2_pkg::l2_req_t bank_req_o   [NB_BANKS],
   input  l2_pkg::l2_rsp_t bank_rsp_i   [NB_BANKS],
   output l2_pkg::l2_req_t pri_req_o    [2],
   input  l2_pkg::l2_rsp_t pri_rsp_i    [2]
);

   // Interleaved banks first, then the two private banks
   localparam int unsigned NB_PORTS  = NB_BANKS + 2;
   localparam int unsigned PORT_W    = $clog2(NB_PORTS);
   localparam int unsigned SEL_SHIFT = $clog2(NB_BANKS);
   localparam logic [31:0] INTL_SIZE = 32'(NB_BANKS * INTL_BANK_WORDS * 4);
   localparam logic [31:0] PRI_SIZE  = 32'(PRI_BANK_WORDS * 4);

   l2_pkg::l2_target_e    tgt      [NB_MASTERS];
   logic [PORT_W-1:0]     port_sel [NB_MASTERS];
   l2_pkg::l2_req_t       fwd_req  [NB_MASTERS];
   logic [31:0]           intl_off [NB_MASTERS];
   logic [31:0]           pri0_off [NB_MASTERS];
   logic [31:0]           pri1_off [NB_MASTERS];

   logic [NB_MASTERS-1:0] arb_req  [NB_PORTS];
   logic [NB_MASTERS-1:0] arb_gnt  [NB_PORTS];
   l2_pkg::l2_req_t       port_req [NB_PORTS];
   l2_pkg::l2_rsp_t       port_rsp [NB_PORTS];

   // Routing record, one entry per master
   l2_pkg::l2_target_e    rec_tgt_q  [NB_MASTERS];
   logic [PORT_W-1:0]     rec_port_q [NB_MASTERS];
   logic [NB_MASTERS-1:0] rec_err_q;

   for (genvar m = 0; m < NB_MASTERS; m++) begin : g_master
      logic master_gnt;

      // Offsets wrap around so addresses below a base miss too
      always_comb begin
         intl_off[m] = master_req_i[m].add - `SOC_MEM_MAP_TCDM_START_ADDR;
         pri0_off[m] = master_req_i[m].add - `SOC_MEM_MAP_PRIVATE_BANK0_START_ADDR;
         pri1_off[m] = master_req_i[m].add - `SOC_MEM_MAP_PRIVATE_BANK1_START_ADDR;
         fwd_req[m]  = master_req_i[m];
         port_sel[m] = '0;
         if (intl_off[m] < INTL_SIZE) begin
            tgt[m]      = l2_pkg::TGT_INTL;
            port_sel[m] = PORT_W'((intl_off[m] >> 2) & 32'(NB_BANKS - 1));
            // Strip bank select and keep the region base
            fwd_req[m].add = `SOC_MEM_MAP_TCDM_START_ADDR
                             + ((intl_off[m] >> (2 + SEL_SHIFT)) << 2);
         end else if (pri0_off[m] < PRI_SIZE) begin
            tgt[m]      = l2_pkg::TGT_PRI0;
            port_sel[m] = PORT_W'(NB_BANKS);
         end else if (pri1_off[m] < PRI_SIZE) begin
            tgt[m]      = l2_pkg::TGT_PRI1;
            port_sel[m] = PORT_W'(NB_BANKS + 1);
         end else begin
            tgt[m] = l2_pkg::TGT_NONE;
         end
      end

      // Unmapped requests never wait
      assign master_gnt = (tgt[m] == l2_pkg::TGT_NONE) ? master_req_i[m].req
                        : (arb_gnt[port_sel[m]][m] & port_rsp[port_sel[m]].gnt);

      always_ff @(posedge clk_i or negedge rst_ni) begin
         if (!rst_ni) begin
            rec_tgt_q[m]  <= l2_pkg::TGT_NONE;
            rec_port_q[m] <= '0;
            rec_err_q[m]  <= 1'b0;
         end else begin
            rec_tgt_q[m]  <= master_gnt ? tgt[m] : l2_pkg::TGT_NONE;
            rec_port_q[m] <= port_sel[m];
            rec_err_q[m]  <= master_gnt && (tgt[m] == l2_pkg::TGT_NONE);
         end
      end

      // Steer the response of last cycle's grant
      always_comb begin
         master_rsp_o[m].gnt     = master_gnt;
         master_rsp_o[m].r_valid = 1'b0;
         master_rsp_o[m].r_opc   = l2_pkg::OPC_OK;
         master_rsp_o[m].r_rdata = '0;
         if (rec_tgt_q[m] != l2_pkg::TGT_NONE) begin
            master_rsp_o[m].r_valid = port_rsp[rec_port_q[m]].r_valid;
            master_rsp_o[m].r_opc   = port_rsp[rec_port_q[m]].r_opc;
            master_rsp_o[m].r_rdata = port_rsp[rec_port_q[m]].r_rdata;
         end else if (rec_err_q[m]) begin
            master_rsp_o[m].r_valid = 1'b1;
            master_rsp_o[m].r_opc   = l2_pkg::OPC_ERR;
         end
      end
   end

   for (genvar p = 0; p < NB_PORTS; p++) begin : g_port
      always_comb begin
         for (int unsigned m = 0; m < NB_MASTERS; m++) begin
            arb_req[p][m] = master_req_i[m].req && (tgt[m] != l2_pkg::TGT_NONE)
                            && (port_sel[m] == PORT_W'(p));
         end
      end

      l2_rr_arbiter #(
         .NB_MASTERS ( NB_MASTERS )
      ) u_arbiter (
         .clk_i  ( clk_i      ),
         .rst_ni ( rst_ni     ),
         .req_i  ( arb_req[p] ),
         .gnt_o  ( arb_gnt[p] )
      );

      // An idle bank sees all zeros
      always_comb begin
         port_req[p] = '0;
         for (int unsigned m = 0; m < NB_MASTERS; m++) begin
            if (arb_gnt[p][m]) begin
               port_req[p] = fwd_req[m];
            end
         end
      end
   end

   for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank_map
      assign bank_req_o[b] = port_req[b];
      assign port_rsp[b]   = bank_rsp_i[b];
   end

   for (genvar p = 0; p < 2; p++) begin : g_pri_map
      assign pri_req_o[p]          = port_req[NB_BANKS + p];
      assign port_rsp[NB_BANKS + p] = pri_rsp_i[p];
   end

endmodule

// File: hw/l2_pkg.sv
/*
 * L2 memory subsystem types
 * Request and response structs of the request/grant protocol, the
 * response opcode and the routing target used by the interconnect
 */

package l2_pkg;

   // Response status returned with r_valid
   typedef enum logic [0:0] {
      OPC_OK  = 1'b0,
      OPC_ERR = 1'b1
   } l2_opc_e;

   // Where a granted request was routed
   typedef enum logic [1:0] {
      TGT_INTL = 2'd0, // Interleaved region
      TGT_PRI0 = 2'd1,
      TGT_PRI1 = 2'd2,
      TGT_NONE = 2'd3  // Unmapped or idle
   } l2_target_e;

   // Master to memory
   typedef struct packed {
      logic        req;
      logic [31:0] add;   // Byte address
      logic        wen;   // Low for write
      logic [3:0]  be;
      logic [31:0] wdata;
   } l2_req_t;

   // Memory to master
   typedef struct packed {
      logic        gnt;
      logic        r_valid;
      l2_opc_e     r_opc;
      logic [31:0] r_rdata;
   } l2_rsp_t;

endpackage

// File: hw/l2_ram_multi_bank.sv
/*
 * L2 multi-bank memory
 * Word-interleaved banks plus two private banks, each with a constant
 * one-cycle request/grant handshake
 */

`timescale 1ns/10ps

`include "soc_mem_map.svh"

module l2_ram_multi_bank #(
   parameter int unsigned NB_BANKS        = 4,
   parameter int unsigned INTL_BANK_WORDS = 256,
   parameter int unsigned PRI_BANK_WORDS  = 256
) (
   input  logic            clk_i,
   input  logic            rst_ni,
   input  l2_pkg::l2_req_t mem_req_i [NB_BANKS],
   output l2_pkg::l2_rsp_t mem_rsp_o [NB_BANKS],
   input  l2_pkg::l2_req_t pri_req_i [2],
   output l2_pkg::l2_rsp_t pri_rsp_o [2]
);

   localparam int unsigned INTL_AW = $clog2(INTL_BANK_WORDS);
   localparam int unsigned PRI_AW  = $clog2(PRI_BANK_WORDS);

   logic [NB_BANKS-1:0] intl_valid_q;
   logic [31:0]         intl_addr  [NB_BANKS];
   logic [31:0]         intl_rdata [NB_BANKS];

   logic [1:0]          pri_valid_q;
   logic [31:0]         pri_addr  [2];
   logic [31:0]         pri_rdata [2];

   for (genvar i = 0; i < NB_BANKS; i++) begin : g_intl
      // Grant whenever asked with fixed read latency
      assign mem_rsp_o[i] = '{gnt:     mem_req_i[i].req,
                              r_valid: intl_valid_q[i],
                              r_opc:   l2_pkg::OPC_OK,
                              r_rdata: intl_rdata[i]};

      always_ff @(posedge clk_i or negedge rst_ni) begin
         if (!rst_ni) begin
            intl_valid_q[i] <= 1'b0;
         end else begin
            intl_valid_q[i] <= mem_req_i[i].req;
         end
      end

      assign intl_addr[i] = mem_req_i[i].add - `SOC_MEM_MAP_TCDM_START_ADDR;

      l2_sram_bank #(
         .WORDS ( INTL_BANK_WORDS )
      ) u_bank (
         .clk_i   ( clk_i                         ),
         .csn_i   ( ~mem_req_i[i].req             ),
         .wen_i   ( mem_req_i[i].wen              ),
         .be_i    ( mem_req_i[i].be               ),
         .addr_i  ( intl_addr[i][INTL_AW+1:2]     ), // Byte to word address
         .wdata_i ( mem_req_i[i].wdata            ),
         .rdata_o ( intl_rdata[i]                 )
      );
   end

   for (genvar p = 0; p < 2; p++) begin : g_pri
      localparam logic [31:0] PRI_BASE = (p == 0) ? `SOC_MEM_MAP_PRIVATE_BANK0_START_ADDR
                                                  : `SOC_MEM_MAP_PRIVATE_BANK1_START_ADDR;

      assign pri_rsp_o[p] = '{gnt:     pri_req_i[p].req,
                              r_valid: pri_valid_q[p],
                              r_opc:   l2_pkg::OPC_OK,
                              r_rdata: pri_rdata[p]};

      always_ff @(posedge clk_i or negedge rst_ni) begin
         if (!rst_ni) begin
            pri_valid_q[p] <= 1'b0;
         end else begin
            pri_valid_q[p] <= pri_req_i[p].req;
         end
      end

      assign pri_addr[p] = pri_req_i[p].add - PRI_BASE; // Window offset

      l2_sram_bank #(
         .WORDS ( PRI_BANK_WORDS )
      ) u_bank (
         .clk_i   ( clk_i                     ),
         .csn_i   ( ~pri_req_i[p].req         ),
         .wen_i   ( pri_req_i[p].wen          ),
         .be_i    ( pri_req_i[p].be           ),
         .addr_i  ( pri_addr[p][PRI_AW+1:2]   ),
         .wdata_i ( pri_req_i[p].wdata        ),
         .rdata_o ( pri_rdata[p]              )
      );
   end

endmodule

// File: hw/l2_rr_arbiter.sv
/*
 * Round-robin arbiter
 * Grants one requester per cycle, searching from a rotating pointer
 * that moves past the winner after each grant
 */

`timescale 1ns/10ps

module l2_rr_arbiter #(
   parameter int unsigned NB_MASTERS = 2
) (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic [NB_MASTERS-1:0] req_i,
   output logic [NB_MASTERS-1:0] gnt_o
);

   localparam int unsigned PTR_W = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1;

   logic [PTR_W-1:0] ptr_q;   // Highest priority master
   logic [PTR_W-1:0] winner;
   logic             found;

   // Scan from the pointer and take the first requester
   always_comb begin
      int unsigned idx;
      gnt_o  = '0;
      found  = 1'b0;
      winner = ptr_q;
      for (int unsigned i = 0; i < NB_MASTERS; i++) begin
         idx = (ptr_q + i) % NB_MASTERS;
         if (!found && req_i[idx]) begin
            gnt_o[idx] = 1'b1;
            found      = 1'b1;
            winner     = PTR_W'(idx);
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         ptr_q <= '0;
      end else if (found) begin
         // Next in line after the winner
         if (winner == PTR_W'(NB_MASTERS - 1)) begin
            ptr_q <= '0;
         end else begin
            ptr_q <= winner + 1'b1;
         end
      end
   end

endmodule

// File: hw/l2_sram_bank.sv
/*
 * Single-port SRAM bank
 * Byte-enabled writes, read data registered and valid one cycle later
 */

`timescale 1ns/10ps

module l2_sram_bank #(
   parameter int unsigned WORDS = 256
) (
   input  logic                     clk_i,
   input  logic                     csn_i,
   input  logic                     wen_i,
   input  logic [3:0]               be_i,
   input  logic [$clog2(WORDS)-1:0] addr_i,
   input  logic [31:0]              wdata_i,
   output logic [31:0]              rdata_o
);

   logic [31:0] mem [WORDS];

   always_ff @(posedge clk_i) begin
      if (!csn_i) begin
         if (!wen_i) begin
            // Write only the enabled byte lanes
            for (int b = 0; b < 4; b++) begin
               if (be_i[b]) begin
                  mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
               end
            end
         end else begin
            rdata_o <= mem[addr_i]; // Read port
         end
      end
   end

endmodule

// File: hw/l2_subsystem_top.sv
/*
 * L2 memory subsystem
 * Interconnect in front of the interleaved and private SRAM banks
 */

`timescale 1ns/10ps

module l2_subsystem_top #(
   parameter int unsigned NB_MASTERS      = 2,
   parameter int unsigned NB_BANKS        = 4,
   parameter int unsigned INTL_BANK_WORDS = 256,
   parameter int unsigned PRI_BANK_WORDS  = 256
) (
   input  logic            clk_i,
   input  logic            rst_ni,
   input  l2_pkg::l2_req_t master_req_i [NB_MASTERS],
   output l2_pkg::l2_rsp_t master_rsp_o [NB_MASTERS]
);

   l2_pkg::l2_req_t bank_req [NB_BANKS];
   l2_pkg::l2_rsp_t bank_rsp [NB_BANKS];
   l2_pkg::l2_req_t pri_req  [2];
   l2_pkg::l2_rsp_t pri_rsp  [2];

   l2_interconnect #(
      .NB_MASTERS      ( NB_MASTERS      ),
      .NB_BANKS        ( NB_BANKS        ),
      .INTL_BANK_WORDS ( INTL_BANK_WORDS ),
      .PRI_BANK_WORDS  ( PRI_BANK_WORDS  )
   ) u_interconnect (
      .clk_i        ( clk_i        ),
      .rst_ni       ( rst_ni       ),
      .master_req_i ( master_req_i ),
      .master_rsp_o ( master_rsp_o ),
      .bank_req_o   ( bank_req     ),
      .bank_rsp_i   ( bank_rsp     ),
      .pri_req_o    ( pri_req      ),
      .pri_rsp_i    ( pri_rsp      )
   );

   l2_ram_multi_bank #(
      .NB_BANKS        ( NB_BANKS        ),
      .INTL_BANK_WORDS ( INTL_BANK_WORDS ),
      .PRI_BANK_WORDS  ( PRI_BANK_WORDS  )
   ) u_ram (
      .clk_i     ( clk_i    ),
      .rst_ni    ( rst_ni   ),
      .mem_req_i ( bank_req ),
      .mem_rsp_o ( bank_rsp ),
      .pri_req_i ( pri_req  ),
      .pri_rsp_o ( pri_rsp  )
   );

endmodule

// File: hw/soc_mem_map.svh
/*
 * SoC memory map
 * Base addresses of the interleaved L2 region and the two private banks
 */

`ifndef SOC_MEM_MAP_SVH
`define SOC_MEM_MAP_SVH

`define SOC_MEM_MAP_TCDM_START_ADDR          32'h1C00_0000
`define SOC_MEM_MAP_PRIVATE_BANK0_START_ADDR 32'h1C10_0000
`define SOC_MEM_MAP_PRIVATE_BANK1_START_ADDR 32'h1C20_0000

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build the L2 subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 -f tb.f --top-module tb_l2_subsystem > build.log 2>&1 ||
   { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_l2_subsystem > sim.log 2>&1
cat sim.log
grep -q "Verification passed" sim.log && exit 0 || exit 1

// File: tb.f
+incdir+hw
hw/l2_pkg.sv
hw/l2_sram_bank.sv
hw/l2_rr_arbiter.sv
hw/l2_interconnect.sv
hw/l2_ram_multi_bank.sv
hw/l2_subsystem_top.sv
verification/tb_l2_subsystem.sv

// File: verification/tb_l2_subsystem.sv
/*
 * L2 subsystem testbench
 * Directed tests on two masters, checked against a reference word model
 */

`timescale 1ns/10ps

`include "soc_mem_map.svh"

module tb_l2_subsystem;

   localparam int unsigned NB_MASTERS = 2;
   localparam int unsigned NB_BANKS   = 4;
   localparam int unsigned WORDS      = 256; // Words per bank in both regions
   localparam logic [31:0] INTL_BASE  = `SOC_MEM_MAP_TCDM_START_ADDR;
   localparam logic [31:0] PRI0_BASE  = `SOC_MEM_MAP_PRIVATE_BANK0_START_ADDR;
   localparam logic [31:0] PRI1_BASE  = `SOC_MEM_MAP_PRIVATE_BANK1_START_ADDR;
   localparam logic [31:0] INTL_SIZE  = 32'(NB_BANKS * WORDS * 4);
   localparam logic [31:0] PRI_SIZE   = 32'(WORDS * 4);
   localparam int unsigned TIMEOUT_NS = 600 * 100 * 4;

   logic                  clk_i;
   logic                  rst_ni;
   l2_pkg::l2_req_t       req [NB_MASTERS];
   l2_pkg::l2_rsp_t       rsp [NB_MASTERS];
   logic [31:0]           model [int unsigned]; // Words by word address
   logic [31:0]           lcg_state = 32'd14;
   int unsigned           errors    = 0;
   int unsigned           last_wait;
   logic [NB_MASTERS-1:0] gnt_seen;
   logic [NB_MASTERS-1:0] pend_v;   // Response due in the next cycle
   logic [NB_MASTERS-1:0] pend_rd;  // Data of that response is checked
   l2_pkg::l2_opc_e       pend_opc  [NB_MASTERS];
   logic [31:0]           pend_data [NB_MASTERS];

   l2_subsystem_top #(
      .NB_MASTERS      ( NB_MASTERS ),
      .NB_BANKS        ( NB_BANKS   ),
      .INTL_BANK_WORDS ( WORDS      ),
      .PRI_BANK_WORDS  ( WORDS      )
   ) u_l2_subsystem_top (
      .clk_i        ( clk_i  ),
      .rst_ni       ( rst_ni ),
      .master_req_i ( req    ),
      .master_rsp_o ( rsp    )
   );

   initial clk_i = 1'b0;
   always #50 clk_i = ~clk_i;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Word w of interleaved bank b
   function automatic logic [31:0] intl_addr(input int unsigned bank, input int unsigned word);
      return INTL_BASE + 32'((word * NB_BANKS + bank) * 4);
   endfunction

   function automatic bit is_mapped(input logic [31:0] a);
      return (a >= INTL_BASE && a < INTL_BASE + INTL_SIZE)
          || (a >= PRI0_BASE && a < PRI0_BASE + PRI_SIZE)
          || (a >= PRI1_BASE && a < PRI1_BASE + PRI_SIZE);
   endfunction

   function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                         input logic [3:0] be);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            res[8*b +: 8] = wd[8*b +: 8];
         end
      end
      return res;
   endfunction

   task automatic drive(input int m, input logic [31:0] addr, input logic wr,
                        input logic [3:0] byte_en, input logic [31:0] data);
      req[m] = '{req: 1'b1, add: addr, wen: ~wr, be: byte_en, wdata: data};
   endtask

   // Checks last cycle's responses and records this cycle's grants at the falling edge
   task automatic step(input string name);
      int unsigned word_addr;
      @(negedge clk_i);
      for (int m = 0; m < NB_MASTERS; m++) begin
         if (pend_v[m] && !rsp[m].r_valid) begin
            $display("%s: master %0d got no r_valid one cycle after its grant", name, m);
            errors++;
         end else if (pend_v[m]) begin
            if (rsp[m].r_opc !== pend_opc[m]) begin
               $display("ERROR %s: master %0d opcode expected %0d actual %0d",
                        name, m, pend_opc[m], rsp[m].r_opc);
               errors++;
            end
            if (pend_rd[m] && rsp[m].r_rdata !== pend_data[m]) begin
               $display("ERROR %s: master %0d rdata expected %08h actual %08h",
                        name, m, pend_data[m], rsp[m].r_rdata);
               errors++;
            end
         end else if (rsp[m].r_valid) begin
            $display("%s: master %0d got r_valid with no grant before it", name, m);
            errors++;
         end
         gnt_seen[m]  = req[m].req && rsp[m].gnt;
         pend_v[m]    = gnt_seen[m];
         pend_rd[m]   = 1'b0;
         pend_opc[m]  = l2_pkg::OPC_OK;
         pend_data[m] = 32'h0;
         word_addr    = req[m].add >> 2;
         if (gnt_seen[m] && !is_mapped(req[m].add)) begin
            pend_opc[m] = l2_pkg::OPC_ERR; // Zero data expected
            pend_rd[m]  = 1'b1;
         end else if (gnt_seen[m] && !req[m].wen) begin
            model[word_addr] = merge(model.exists(word_addr) ? model[word_addr] : 32'h0,
                                     req[m].wdata, req[m].be);
         end else if (gnt_seen[m]) begin
            pend_rd[m]   = 1'b1;
            pend_data[m] = model[word_addr];
         end
      end
      @(posedge clk_i);
      #1;
   endtask

   // Single transaction with the request held until granted
   task automatic access(input int m, input logic [31:0] addr, input logic wr,
                         input logic [3:0] byte_en, input logic [31:0] data, input string name);
      last_wait = 0;
      drive(m, addr, wr, byte_en, data);
      step(name);
      while (!gnt_seen[m] && last_wait < 4 * NB_MASTERS) begin
         last_wait++;
         step(name);
      end
      if (!gnt_seen[m]) begin
         $display("%s: master %0d never got a grant for address %08h", name, m, addr);
         errors++;
      end
      req[m].req = 1'b0;
      step(name);
   endtask

   task automatic apply_reset();
      rst_ni = 1'b0;
      for (int m = 0; m < NB_MASTERS; m++) begin
         req[m] = '0;
      end
      pend_v   = '0;
      gnt_seen = '0;
      repeat (3) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;
   endtask

   task automatic write_read_back();
      logic [31:0] addr;
      for (int i = 0; i < 12; i++) begin
         case (i % 3)
            0:       addr = PRI0_BASE + (((next_rand() >> 16) % WORDS) << 2);
            1:       addr = PRI1_BASE + (((next_rand() >> 16) % WORDS) << 2);
            default: addr = intl_addr(i / 3, (next_rand() >> 16) % WORDS);
         endcase
         access(0, addr, 1'b1, 4'hF, next_rand(), "basic");
         access(0, addr, 1'b0, 4'hF, 32'h0, "basic");
      end
   endtask

   task automatic byte_enables();
      logic [31:0] addr [2];
      addr[0] = intl_addr(1, 7);
      addr[1] = PRI1_BASE + 32'h20;
      access(0, addr[0], 1'b1, 4'hF, next_rand(), "byte_en");
      access(0, addr[1], 1'b1, 4'hF, next_rand(), "byte_en");
      for (int pat = 0; pat < 16; pat++) begin
         access(0, addr[pat % 2], 1'b1, 4'(pat), next_rand(), "byte_en");
         access(0, addr[pat % 2], 1'b0, 4'hF, 32'h0, "byte_en");
      end
   endtask

   task automatic parallel_banks();
      logic [31:0] a0;
      logic [31:0] a1;
      for (int i = 0; i < 8; i++) begin
         a0 = intl_addr(i % NB_BANKS, (next_rand() >> 16) % WORDS);
         a1 = (i % 2 == 0) ? intl_addr((i + 1) % NB_BANKS, (next_rand() >> 16) % WORDS)
                           : PRI0_BASE + (((next_rand() >> 16) % WORDS) << 2);
         for (int rd = 0; rd < 2; rd++) begin
            drive(0, a0, rd == 0, 4'hF, next_rand());
            drive(1, a1, rd == 0, 4'hF, next_rand());
            step("parallel");
            if (gnt_seen != '1) begin
               $display("parallel: both masters should be granted together, grants %b", gnt_seen);
               errors++;
            end
            req[0].req = 1'b0;
            req[1].req = 1'b0;
            step("parallel");
         end
      end
   endtask

   // Both masters hammer bank 2 with three writes and three read-backs each
   task automatic bank_contention();
      int unsigned cnt [NB_MASTERS];
      int          winner;
      apply_reset();
      winner = 0;
      for (int m = 0; m < NB_MASTERS; m++) begin
         cnt[m] = 0;
         drive(m, intl_addr(2, 20 * m), 1'b1, 4'hF, next_rand());
      end
      for (int n = 0; n < 12; n++) begin
         step("contention");
         if (gnt_seen[winner] !== 1'b1 || gnt_seen[1 - winner] !== 1'b0) begin
            $display("contention: round %0d should grant only master %0d, grants %b",
                     n, winner, gnt_seen);
            errors++;
         end
         for (int m = 0; m < NB_MASTERS; m++) begin
            if (gnt_seen[m] && cnt[m] < 5) begin
               cnt[m]++;
               drive(m, intl_addr(2, 20 * m + cnt[m] % 3), cnt[m] < 3, 4'hF, next_rand());
            end else if (gnt_seen[m]) begin
               req[m].req = 1'b0;
            end
         end
         winner = 1 - winner;
      end
      step("contention");
   endtask

   task automatic pipelined_reads();
      for (int i = 0; i < 16; i++) begin
         drive(1, INTL_BASE + 32'h200 + 32'((i % 8) * 4), i < 8, 4'hF, next_rand());
         step("pipeline");
         if (!gnt_seen[1]) begin
            $display("pipeline: master 1 was not granted in cycle %0d without contention", i);
            errors++;
         end
      end
      req[1].req = 1'b0;
      step("pipeline");
   endtask

   task automatic unmapped_access();
      logic [31:0] bad;
      access(0, INTL_BASE, 1'b1, 4'hF, 32'hA5A5_0001, "unmapped");
      access(0, PRI0_BASE, 1'b1, 4'hF, 32'hA5A5_0002, "unmapped");
      access(0, PRI1_BASE, 1'b1, 4'hF, 32'hA5A5_0003, "unmapped");
      for (int i = 0; i < 4; i++) begin
         case (i)
            0:       bad = INTL_BASE + INTL_SIZE; // Would alias word 0 if size were ignored
            1:       bad = PRI0_BASE + PRI_SIZE;
            2:       bad = PRI1_BASE + PRI_SIZE;
            default: bad = 32'h0;
         endcase
         access(i % 2, bad, 1'b1, 4'hF, 32'hDEAD_BEEF, "unmapped");
         if (last_wait != 0) begin
            $display("unmapped: access to %08h was not granted at once", bad);
            errors++;
         end
         access(i % 2, bad, 1'b0, 4'hF, 32'h0, "unmapped");
      end
      access(0, INTL_BASE, 1'b0, 4'hF, 32'h0, "unmapped");
      access(0, PRI0_BASE, 1'b0, 4'hF, 32'h0, "unmapped");
      access(0, PRI1_BASE, 1'b0, 4'hF, 32'h0, "unmapped");
   endtask

   initial begin
      apply_reset();
      write_read_back();
      byte_enables();
      parallel_banks();
      bank_contention();
      pipelined_reads();
      unmapped_access();
      $display("Done with %0d errors", errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
      $display("Verification failed");
      $finish;
   end

endmodule
